// File: run.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ex_tb \
	-f src.f -Mdir obj_dir -o ex_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/ex_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" sim.log; then
	exit 0
fi
echo "Simulation did not report success"
exit 1

// File: src.f
src/br_pkg.sv
src/ex_pkg.sv
src/operand_mux.sv
src/int_alu.sv
src/divider.sv
src/ex_retire.sv
src/ex_stage.sv
verif/ex_tb.sv

// File: src/br_pkg.sv
`default_nettype none

package br_pkg;

	// Bit 0 inverts the test within the EQ/NE and ordered pairs
	typedef enum logic [2:0] {
		BR_NONE = 3'b000,
		BR_UNC  = 3'b001,
		BR_EQ   = 3'b010,
		BR_NE   = 3'b011,
		BR_LT   = 3'b100,
		BR_GE   = 3'b101,
		BR_LTU  = 3'b110,
		BR_GEU  = 3'b111
	} br_cond_e;

	typedef struct packed {
		br_cond_e cond;
		// JALR style target
		logic     reg_rel;
	} br_ctrl_t;

endpackage

`default_nettype wire

// File: src/divider.sv
`default_nettype none

module divider #(
	parameter int DIV_BITS = 1
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	input  ex_pkg::operands_t opnd,
	input  ex_pkg::alu_func_e func,
	output logic [31:0]       quotient,
	output logic [31:0]       remainder,
	output logic              busy,
	output logic              done
);

	localparam int STEPS = 32 / DIV_BITS;

	logic        is_signed;
	logic [31:0] dvd_abs;
	logic [31:0] dvs_abs;
	logic [63:0] first_step;
	logic [63:0] next_step;
	logic [31:0] rem_q;
	logic [31:0] quo_q;
	logic [31:0] dvs_q;
	logic        q_neg;
	logic        r_neg;
	logic [5:0]  cnt;

	if (DIV_BITS != 1 && DIV_BITS != 2) begin : g_bad_div_bits
		$error("divider: DIV_BITS must be 1 or 2");
	end

	// Restoring steps, dividend bits shift out of the quotient register
	function automatic logic [63:0] div_step(
		input logic [31:0] r,
		input logic [31:0] q,
		input logic [31:0] d
	);
		logic [32:0] diff;
		logic [31:0] rr;
		logic [31:0] qq;
		rr = r;
		qq = q;
		for (int i = 0; i < DIV_BITS; i++) begin
			diff = {rr, qq[31]} - {1'b0, d};
			if (!diff[32]) begin
				rr = diff[31:0];
				qq = {qq[30:0], 1'b1};
			end else begin
				rr = {rr[30:0], qq[31]};
				qq = {qq[30:0], 1'b0};
			end
		end
		return {rr, qq};
	endfunction

	assign is_signed = (func == ex_pkg::ALU_DIV) || (func == ex_pkg::ALU_REM);
	assign dvd_abs = (is_signed && opnd.opa[31]) ? -opnd.opa : opnd.opa;
	assign dvs_abs = (is_signed && opnd.opb[31]) ? -opnd.opb : opnd.opb;

	// First step is taken in the start cycle
	assign first_step = div_step(32'd0, dvd_abs, dvs_abs);
	assign next_step  = div_step(rem_q, quo_q, dvs_q);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt  <= 6'd0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt  <= 6'(STEPS - 1);
			end else if (busy) begin
				cnt <= cnt - 6'd1;
				if (cnt == 6'd1) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			{rem_q, quo_q} <= first_step;
			dvs_q          <= dvs_abs;
			// Zero divisor keeps the all-ones quotient unsigned
			q_neg <= is_signed && (opnd.opa[31] ^ opnd.opb[31]) && (|opnd.opb);
			r_neg <= is_signed && opnd.opa[31];
		end else if (busy) begin
			{rem_q, quo_q} <= next_step;
		end
	end

	// MIN / -1 falls out of the sign fix-up
	assign quotient  = q_neg ? -quo_q : quo_q;
	assign remainder = r_neg ? -rem_q : rem_q;

	a_no_restart: assert property (
		@(posedge clk) disable iff (!arst_n) start |-> !busy && !done
	) else $error("divider: start while busy");

endmodule

`default_nettype wire

// File: src/ex_pkg.sv
`default_nettype none

package ex_pkg;

	// Codes 18 to 31 are illegal
	typedef enum logic [4:0] {
		ALU_ADD    = 5'd0,
		ALU_SUB    = 5'd1,
		ALU_XOR    = 5'd2,
		ALU_OR     = 5'd3,
		ALU_AND    = 5'd4,
		ALU_SLL    = 5'd5,
		ALU_SRL    = 5'd6,
		ALU_SRA    = 5'd7,
		ALU_SLT    = 5'd8,
		ALU_SLTU   = 5'd9,
		ALU_MUL    = 5'd10,
		ALU_MULH   = 5'd11,
		ALU_MULHSU = 5'd12,
		ALU_MULHU  = 5'd13,
		ALU_DIV    = 5'd14,
		ALU_DIVU   = 5'd15,
		ALU_REM    = 5'd16,
		ALU_REMU   = 5'd17
	} alu_func_e;

	// 2'b11 reserved
	typedef enum logic [1:0] {
		FWD_RF  = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_e;

	typedef enum logic [1:0] {
		OPA_RS1  = 2'd0,
		OPA_PC   = 2'd1,
		OPA_ZERO = 2'd2
	} opa_sel_e;

	typedef enum logic [1:0] {
		OPB_RS2  = 2'd0,
		OPB_IMM  = 2'd1,
		OPB_FOUR = 2'd2
	} opb_sel_e;

	typedef struct packed {
		logic [31:0]       rs1_data;
		logic [31:0]       rs2_data;
		logic [31:0]       pc;
		logic [31:0]       imm;
		logic [31:0]       mem_fwd;
		logic [31:0]       wb_fwd;
		fwd_sel_e          fwd1;
		fwd_sel_e          fwd2;
		opa_sel_e          opa_sel;
		opb_sel_e          opb_sel;
		alu_func_e         func;
		br_pkg::br_ctrl_t  br;
	} ex_op_t;

	typedef struct packed {
		logic   cyc;
		logic   stb;
		ex_op_t op;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic        vld;
		logic [31:0] res;
		logic [31:0] mem_din;
		logic        take_br;
		logic [31:0] br_pc;
	} wb_rsp_t;

	typedef struct packed {
		logic [31:0] opa;
		logic [31:0] opb;
		logic [31:0] rs1_fwd;
	} operands_t;

endpackage

`default_nettype wire

// File: src/ex_retire.sv
`default_nettype none

module ex_retire (
	input  logic              clk,
	input  logic              arst_n,
	input  ex_pkg::wb_req_t   req,
	input  ex_pkg::operands_t opnd,
	input  logic [31:0]       mem_din,
	input  logic [31:0]       alu_res,
	input  logic              alu_legal,
	input  logic [31:0]       quotient,
	input  logic [31:0]       remainder,
	input  logic              div_done,
	output logic              div_start,
	output ex_pkg::wb_rsp_t   rsp
);

	typedef enum logic {
		ST_IDLE,
		ST_DIV_WAIT
	} state_e;

	state_e      state;
	logic        ack_q;
	logic        vld_q;
	logic        take_br_q;
	logic [31:0] res_q;
	logic [31:0] din_q;
	logic [31:0] br_pc_q;
	logic        is_div;
	logic        new_req;
	logic        finish;
	logic        vld;
	logic        take_br;
	logic [31:0] result;
	logic [31:0] br_pc;

	assign is_div = req.op.func inside {ex_pkg::ALU_DIV, ex_pkg::ALU_DIVU,
		ex_pkg::ALU_REM, ex_pkg::ALU_REMU};

	// A strobe still high in the ack cycle is the old one
	assign new_req   = req.cyc && req.stb && !ack_q && (state == ST_IDLE);
	assign div_start = new_req && is_div;
	assign finish    = (new_req && !is_div) || ((state == ST_DIV_WAIT) && div_done);

	always_comb begin
		if (!is_div) begin
			result = alu_res;
		end else if (req.op.func inside {ex_pkg::ALU_DIV, ex_pkg::ALU_DIVU}) begin
			result = quotient;
		end else begin
			result = remainder;
		end
	end

	assign vld = is_div || alu_legal;

	always_comb begin
		case (req.op.br.cond)
			br_pkg::BR_EQ, br_pkg::BR_NE: take_br = ~((|result) ^ req.op.br.cond[0]);
			br_pkg::BR_LT, br_pkg::BR_GE,
			br_pkg::BR_LTU, br_pkg::BR_GEU: take_br = result[0] ^ req.op.br.cond[0];
			br_pkg::BR_UNC: take_br = 1'b1;
			default:        take_br = 1'b0;
		endcase
		if (!vld) begin
			take_br = 1'b0;
		end
	end

	assign br_pc = req.op.br.reg_rel ? ((opnd.rs1_fwd + req.op.imm) & ~32'h1)
		: (req.op.pc + req.op.imm);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			ack_q     <= 1'b0;
			vld_q     <= 1'b0;
			take_br_q <= 1'b0;
		end else begin
			ack_q <= finish;
			if (div_start) begin
				state <= ST_DIV_WAIT;
			end else if (div_done) begin
				state <= ST_IDLE;
			end
			if (finish) begin
				vld_q     <= vld;
				take_br_q <= take_br;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (finish) begin
			res_q   <= result;
			din_q   <= mem_din;
			br_pc_q <= br_pc;
		end
	end

	always_comb begin
		rsp.ack     = ack_q;
		rsp.vld     = vld_q;
		rsp.res     = res_q;
		rsp.mem_din = din_q;
		rsp.take_br = take_br_q;
		rsp.br_pc   = br_pc_q;
	end

	a_ack_pulse: assert property (
		@(posedge clk) disable iff (!arst_n) ack_q |=> !ack_q
	) else $error("ex_retire: ack high two cycles in a row");

	a_start_vs_ack: assert property (
		@(posedge clk) disable iff (!arst_n) !(div_start && ack_q)
	) else $error("ex_retire: divider started in the ack cycle");

endmodule

`default_nettype wire

// File: src/ex_stage.sv
`default_nettype none

module ex_stage (
	input  logic            clk,
	input  logic            arst_n,
	input  ex_pkg::wb_req_t wb_req,
	output ex_pkg::wb_rsp_t wb_rsp
);

	ex_pkg::operands_t opnd;
	logic [31:0]       mem_din;
	logic [31:0]       alu_res;
	logic              alu_legal;
	logic [31:0]       quotient;
	logic [31:0]       remainder;
	logic              div_start;
	logic              div_done;

	operand_mux i_opnd_mux (
		.clk     (clk),
		.op      (wb_req.op),
		.cyc_stb (wb_req.cyc && wb_req.stb),
		.opnd    (opnd),
		.mem_din (mem_din)
	);

	int_alu i_alu (
		.opnd  (opnd),
		.func  (wb_req.op.func),
		.res   (alu_res),
		.legal (alu_legal)
	);

	// One quotient bit per clock
	divider #(
		.DIV_BITS (1)
	) i_div (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (div_start),
		.opnd      (opnd),
		.func      (wb_req.op.func),
		.quotient  (quotient),
		.remainder (remainder),
		.busy      (),
		.done      (div_done)
	);

	ex_retire i_retire (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (wb_req),
		.opnd      (opnd),
		.mem_din   (mem_din),
		.alu_res   (alu_res),
		.alu_legal (alu_legal),
		.quotient  (quotient),
		.remainder (remainder),
		.div_done  (div_done),
		.div_start (div_start),
		.rsp       (wb_rsp)
	);

endmodule

`default_nettype wire

// File: src/int_alu.sv
`default_nettype none

module int_alu (
	input  ex_pkg::operands_t opnd,
	input  ex_pkg::alu_func_e func,
	output logic [31:0]       res,
	output logic              legal
);

	logic               sign_a;
	logic               sign_b;
	logic signed [32:0] mul_a;
	logic signed [32:0] mul_b;
	logic signed [65:0] product;

	// MULH is signed x signed, MULHSU signed x unsigned
	assign sign_b = (func == ex_pkg::ALU_MULH);
	assign sign_a = sign_b || (func == ex_pkg::ALU_MULHSU);

	// Top bit replaces the sign extension
	assign mul_a = {sign_a && opnd.opa[31], opnd.opa};
	assign mul_b = {sign_b && opnd.opb[31], opnd.opb};

	assign product = mul_a * mul_b;

	always_comb begin
		res   = 32'h0000_0000;
		legal = 1'b1;

		case (func)
			ex_pkg::ALU_ADD: begin
				res = opnd.opa + opnd.opb;
			end
			ex_pkg::ALU_SUB: begin
				res = opnd.opa - opnd.opb;
			end
			ex_pkg::ALU_XOR: begin
				res = opnd.opa ^ opnd.opb;
			end
			ex_pkg::ALU_OR: begin
				res = opnd.opa | opnd.opb;
			end
			ex_pkg::ALU_AND: begin
				res = opnd.opa & opnd.opb;
			end
			ex_pkg::ALU_SLL: begin
				res = opnd.opa << opnd.opb[4:0];
			end
			ex_pkg::ALU_SRL: begin
				res = opnd.opa >> opnd.opb[4:0];
			end
			ex_pkg::ALU_SRA: begin
				res = $signed(opnd.opa) >>> opnd.opb[4:0];
			end
			ex_pkg::ALU_SLT: begin
				res = {31'd0, $signed(opnd.opa) < $signed(opnd.opb)};
			end
			ex_pkg::ALU_SLTU: begin
				res = {31'd0, opnd.opa < opnd.opb};
			end
			ex_pkg::ALU_MUL: begin
				res = product[31:0];
			end
			ex_pkg::ALU_MULH, ex_pkg::ALU_MULHSU, ex_pkg::ALU_MULHU: begin
				res = product[63:32];
			end
			// Divides are handled by the divider
			default: begin
				legal = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/operand_mux.sv
`default_nettype none

module operand_mux (
	input  logic              clk,
	input  ex_pkg::ex_op_t    op,
	input  logic              cyc_stb,
	output ex_pkg::operands_t opnd,
	output logic [31:0]       mem_din
);

	logic [31:0] rs1_fwd;
	logic [31:0] rs2_fwd;

	function automatic logic [31:0] fwd_pick(
		input ex_pkg::fwd_sel_e sel,
		input logic [31:0]      rf_val,
		input logic [31:0]      mem_val,
		input logic [31:0]      wb_val
	);
		case (sel)
			ex_pkg::FWD_MEM: return mem_val;
			ex_pkg::FWD_WB:  return wb_val;
			default:         return rf_val;
		endcase
	endfunction

	// Bypass first, then source select
	assign rs1_fwd = fwd_pick(op.fwd1, op.rs1_data, op.mem_fwd, op.wb_fwd);
	assign rs2_fwd = fwd_pick(op.fwd2, op.rs2_data, op.mem_fwd, op.wb_fwd);

	always_comb begin
		case (op.opa_sel)
			ex_pkg::OPA_RS1: opnd.opa = rs1_fwd;
			ex_pkg::OPA_PC:  opnd.opa = op.pc;
			default:         opnd.opa = 32'h0000_0000;
		endcase

		case (op.opb_sel)
			ex_pkg::OPB_RS2: opnd.opb = rs2_fwd;
			ex_pkg::OPB_IMM: opnd.opb = op.imm;
			default:         opnd.opb = 32'h0000_0004;
		endcase

		// Needed by JALR targets
		opnd.rs1_fwd = rs1_fwd;
	end

	// Store data always comes from the forwarded rs2
	assign mem_din = rs2_fwd;

	a_fwd_code: assert property (
		@(posedge clk) cyc_stb |-> (op.fwd1 != 2'b11) && (op.fwd2 != 2'b11)
	) else $error("operand_mux: reserved forwarding code %b/%b", op.fwd1, op.fwd2);

endmodule

`default_nettype wire

// File: verif/ex_tb.sv
`default_nettype none

module ex_tb;

	localparam int PERIOD    = 40;
	localparam int DRIVE_DLY = 2;
	localparam int N_ALU     = 80;
	localparam int N_MULH    = 32;
	localparam int N_DIV     = 32;
	localparam int N_BR      = 40;
	localparam int N_ILL     = 12;
	localparam int N_HS      = 40;
	localparam int N_OPS     = N_ALU + N_MULH + N_DIV + N_BR + N_ILL + N_HS;

	logic            clk = 1'b0;
	logic            arst_n;
	ex_pkg::wb_req_t wb_req;
	ex_pkg::wb_rsp_t wb_rsp;
	logic [31:0]     lfsr_q = 32'h19cd_42b7;
	int              errors = 0;
	int              tests_run = 0;
	int              tests_failed = 0;
	int              issued = 0;
	int              ack_seen = 0;

	ex_stage i_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	always #(PERIOD / 2) clk = ~clk;

	// Every ack counted, wanted or not
	always @(negedge clk) begin
		if (wb_rsp.ack === 1'b1) begin
			ack_seen++;
		end
	end

	initial begin
		#(N_OPS * 40 * PERIOD + 10 * PERIOD);
		$display("Watchdog expired, the run did not finish in time");
		$display("Test failures found");
		$finish;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [1:0] rand_code3();
		return 2'(rand_bits(8) % 3);
	endfunction

	function automatic logic [31:0] edge_value(input logic [2:0] idx);
		case (idx)
			3'd0: return 32'h8000_0000;
			3'd1: return 32'h8000_0001;
			3'd2: return 32'h7fff_ffff;
			3'd3: return 32'h7fff_fffe;
			3'd4: return 32'hffff_ffff;
			3'd5: return 32'h0000_0001;
			3'd6: return 32'h0000_0000;
			default: return 32'hc000_0000;
		endcase
	endfunction

	function automatic logic [31:0] pick_fwd(input ex_pkg::fwd_sel_e sel,
		input logic [31:0] rf, input logic [31:0] mem, input logic [31:0] wb);
		case (sel)
			ex_pkg::FWD_MEM: return mem;
			ex_pkg::FWD_WB:  return wb;
			default:         return rf;
		endcase
	endfunction

	// RISC-V divide rules, including zero divisor and overflow
	function automatic logic [31:0] div_ref(input ex_pkg::alu_func_e f,
		input logic [31:0] a, input logic [31:0] b);
		logic sgn;
		logic want_rem;
		sgn = (f == ex_pkg::ALU_DIV) || (f == ex_pkg::ALU_REM);
		want_rem = (f == ex_pkg::ALU_REM) || (f == ex_pkg::ALU_REMU);
		if (b == 32'd0) begin
			return want_rem ? a : 32'hffff_ffff;
		end
		if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
			return want_rem ? 32'd0 : a;
		end
		if (sgn) begin
			return want_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
		end
		return want_rem ? a % b : a / b;
	endfunction

	function automatic ex_pkg::wb_rsp_t expect_rsp(input ex_pkg::ex_op_t op);
		ex_pkg::wb_rsp_t r;
		logic [31:0]     rs1f;
		logic [31:0]     rs2f;
		logic [31:0]     a;
		logic [31:0]     b;
		logic [63:0]     wide;
		r = '0;
		rs1f = pick_fwd(op.fwd1, op.rs1_data, op.mem_fwd, op.wb_fwd);
		rs2f = pick_fwd(op.fwd2, op.rs2_data, op.mem_fwd, op.wb_fwd);
		a = (op.opa_sel == ex_pkg::OPA_RS1) ? rs1f
			: (op.opa_sel == ex_pkg::OPA_PC) ? op.pc : 32'd0;
		b = (op.opb_sel == ex_pkg::OPB_RS2) ? rs2f
			: (op.opb_sel == ex_pkg::OPB_IMM) ? op.imm : 32'd4;
		r.ack = 1'b1;
		r.vld = 1'b1;
		r.mem_din = rs2f;
		case (op.func)
			ex_pkg::ALU_ADD:  r.res = a + b;
			ex_pkg::ALU_SUB:  r.res = a - b;
			ex_pkg::ALU_XOR:  r.res = a ^ b;
			ex_pkg::ALU_OR:   r.res = a | b;
			ex_pkg::ALU_AND:  r.res = a & b;
			ex_pkg::ALU_SLL:  r.res = a << b[4:0];
			ex_pkg::ALU_SRL:  r.res = a >> b[4:0];
			ex_pkg::ALU_SRA:  r.res = $signed(a) >>> b[4:0];
			ex_pkg::ALU_SLT:  r.res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ex_pkg::ALU_SLTU: r.res = (a < b) ? 32'd1 : 32'd0;
			ex_pkg::ALU_MUL: begin
				wide = {32'd0, a} * {32'd0, b};
				r.res = wide[31:0];
			end
			ex_pkg::ALU_MULH: begin
				wide = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
				r.res = wide[63:32];
			end
			ex_pkg::ALU_MULHSU: begin
				wide = $signed({{32{a[31]}}, a}) * $signed({32'd0, b});
				r.res = wide[63:32];
			end
			ex_pkg::ALU_MULHU: begin
				wide = {32'd0, a} * {32'd0, b};
				r.res = wide[63:32];
			end
			ex_pkg::ALU_DIV, ex_pkg::ALU_DIVU, ex_pkg::ALU_REM, ex_pkg::ALU_REMU: begin
				r.res = div_ref(op.func, a, b);
			end
			default: r.vld = 1'b0;
		endcase
		case (op.br.cond)
			br_pkg::BR_EQ:                r.take_br = (r.res == 32'd0);
			br_pkg::BR_NE:                r.take_br = (r.res != 32'd0);
			br_pkg::BR_LT, br_pkg::BR_LTU: r.take_br = r.res[0];
			br_pkg::BR_GE, br_pkg::BR_GEU: r.take_br = !r.res[0];
			br_pkg::BR_UNC:               r.take_br = 1'b1;
			default:                      r.take_br = 1'b0;
		endcase
		r.take_br = r.take_br && r.vld;
		r.br_pc = op.br.reg_rel ? ((rs1f + op.imm) & 32'hffff_fffe) : (op.pc + op.imm);
		return r;
	endfunction

	function automatic ex_pkg::ex_op_t random_op(input logic [4:0] f);
		ex_pkg::ex_op_t op;
		op.rs1_data = rand_bits(32);
		op.rs2_data = rand_bits(32);
		op.pc = rand_bits(32);
		op.imm = rand_bits(32);
		op.mem_fwd = rand_bits(32);
		op.wb_fwd = rand_bits(32);
		op.fwd1 = ex_pkg::fwd_sel_e'(rand_code3());
		op.fwd2 = ex_pkg::fwd_sel_e'(rand_code3());
		op.opa_sel = ex_pkg::opa_sel_e'(rand_code3());
		op.opb_sel = ex_pkg::opb_sel_e'(rand_code3());
		op.func = ex_pkg::alu_func_e'(f);
		op.br.cond = br_pkg::BR_NONE;
		op.br.reg_rel = rand_bits(1);
		return op;
	endfunction

	// Register operands straight from the register file
	function automatic ex_pkg::ex_op_t direct_op(input logic [4:0] f,
		input logic [31:0] a, input logic [31:0] b);
		ex_pkg::ex_op_t op;
		op = random_op(f);
		op.rs1_data = a;
		op.rs2_data = b;
		op.fwd1 = ex_pkg::FWD_RF;
		op.fwd2 = ex_pkg::FWD_RF;
		op.opa_sel = ex_pkg::OPA_RS1;
		op.opb_sel = ex_pkg::OPB_RS2;
		return op;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp, input ex_pkg::ex_op_t op);
		$display("[ERROR] %0t: %s is %h, expected %h (func %0d, cond %0d)",
			$time, what, got, exp, op.func, op.br.cond);
		errors++;
	endtask

	// One Wishbone classic cycle, entered and left a short delay after a rising edge
	task automatic run_op(input ex_pkg::ex_op_t op, input int lead, input int gap);
		ex_pkg::wb_rsp_t exp;
		ex_pkg::wb_rsp_t got;
		int              cycles;
		logic            is_div;
		exp = expect_rsp(op);
		is_div = op.func inside {ex_pkg::ALU_DIV, ex_pkg::ALU_DIVU,
			ex_pkg::ALU_REM, ex_pkg::ALU_REMU};
		wb_req.op = op;
		wb_req.cyc = 1'b1;
		repeat (lead) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
		wb_req.stb = 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end while (wb_rsp.ack !== 1'b1);
		got = wb_rsp;
		issued++;
		@(posedge clk);
		#DRIVE_DLY;
		wb_req.stb = 1'b0;
		wb_req.cyc = 1'b0;
		if (!is_div) begin
			assert (cycles == 1)
			else report_mismatch("ack latency", 32'(cycles), 32'd1, op);
		end
		assert (got.vld === exp.vld) else report_mismatch("vld", got.vld, exp.vld, op);
		assert (got.take_br === exp.take_br)
		else report_mismatch("take_br", got.take_br, exp.take_br, op);
		if (exp.vld) begin
			assert (got.res === exp.res)
			else report_mismatch("res", got.res, exp.res, op);
			assert (got.mem_din === exp.mem_din)
			else report_mismatch("mem_din", got.mem_din, exp.mem_din, op);
			assert (got.br_pc === exp.br_pc)
			else report_mismatch("br_pc", got.br_pc, exp.br_pc, op);
		end
		repeat (gap) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
		assert (ack_seen == issued)
		else report_mismatch("ack count", 32'(ack_seen), 32'(issued), op);
	endtask

	task automatic report_test(input string name, input int n_ops, input int err_start);
		tests_run++;
		if (errors != err_start) begin
			tests_failed++;
		end
		$display("test %s: %0d operations, %0d errors", name, n_ops, errors - err_start);
	endtask

	initial begin
		ex_pkg::ex_op_t op;
		int             err_start;
		logic [31:0]    a;
		logic [31:0]    b;

		arst_n = 1'b0;
		wb_req = '0;
		err_start = errors;
		repeat (5) @(posedge clk);
		#DRIVE_DLY;
		arst_n = 1'b1;
		@(negedge clk);
		assert (wb_rsp.ack === 1'b0)
		else report_mismatch("ack after reset", wb_rsp.ack, 32'd0, wb_req.op);
		assert (wb_rsp.vld === 1'b0)
		else report_mismatch("vld after reset", wb_rsp.vld, 32'd0, wb_req.op);
		assert (wb_rsp.take_br === 1'b0)
		else report_mismatch("take_br after reset", wb_rsp.take_br, 32'd0, wb_req.op);
		@(posedge clk);
		#DRIVE_DLY;
		report_test("reset", 0, err_start);

		err_start = errors;
		for (int i = 0; i < N_ALU; i++) begin
			op = random_op(5'(rand_bits(8) % 14));
			run_op(op, 0, 1);
		end
		report_test("alu_random", N_ALU, err_start);

		err_start = errors;
		for (int i = 0; i < N_MULH; i++) begin
			a = edge_value(rand_bits(3));
			b = edge_value(rand_bits(3));
			op = direct_op(5'(10 + i % 4), a, b);
			run_op(op, 0, 1);
		end
		report_test("mul_edges", N_MULH, err_start);

		// Zero divisor and MIN / -1 first
		err_start = errors;
		for (int i = 0; i < 4; i++) begin
			run_op(direct_op(5'(14 + i), rand_bits(32), 32'd0), 0, 1);
			run_op(direct_op(5'(14 + i), 32'h8000_0000, 32'hffff_ffff), 0, 1);
		end
		for (int i = 8; i < N_DIV; i++) begin
			a = rand_bits(32);
			b = rand_bits(2) == 2'd0 ? rand_bits(4) : rand_bits(32);
			op = random_op(5'(14 + rand_bits(2)));
			op.rs1_data = a;
			op.rs2_data = b;
			op.opa_sel = ex_pkg::OPA_RS1;
			op.opb_sel = ex_pkg::OPB_RS2;
			run_op(op, 0, 1);
		end
		report_test("divide", N_DIV, err_start);

		err_start = errors;
		for (int i = 0; i < N_BR; i++) begin
			a = rand_bits(32);
			b = rand_bits(2) == 2'd0 ? a : rand_bits(32);
			op = direct_op(5'(ex_pkg::ALU_ADD), a, b);
			op.br.cond = (i == 0) ? br_pkg::BR_UNC : (i == 1) ? br_pkg::BR_NONE
				: br_pkg::br_cond_e'(rand_bits(3));
			case (op.br.cond)
				br_pkg::BR_EQ, br_pkg::BR_NE:  op.func = ex_pkg::ALU_SUB;
				br_pkg::BR_LT, br_pkg::BR_GE:  op.func = ex_pkg::ALU_SLT;
				br_pkg::BR_LTU, br_pkg::BR_GEU: op.func = ex_pkg::ALU_SLTU;
				default:                       op.func = ex_pkg::ALU_ADD;
			endcase
			run_op(op, 0, 1);
		end
		report_test("branch", N_BR, err_start);

		err_start = errors;
		for (int i = 0; i < N_ILL; i++) begin
			op = random_op(5'(18 + rand_bits(8) % 14));
			op.br.cond = br_pkg::br_cond_e'(rand_bits(3));
			run_op(op, 0, 1);
		end
		report_test("illegal", N_ILL, err_start);

		// Random cyc lead and gaps between operations
		err_start = errors;
		for (int i = 0; i < N_HS; i++) begin
			op = random_op(5'(rand_bits(8) % 18));
			op.br.cond = br_pkg::br_cond_e'(rand_bits(3));
			run_op(op, int'(rand_bits(2)), 1 + int'(rand_bits(2)));
		end
		report_test("handshake", N_HS, err_start);

		$display("Summary: %0d tests run, %0d tests failed, %0d failing checks",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire
